/* design/ppu_ops_pkg.sv */
// #########################################################################
// opcode definitions shared by the posit unit and its wrapper
// import into any module that decodes or forwards an operation
// #########################################################################

`default_nettype none

package ppu_ops_pkg;

  // opcode field width on the top level ports
  localparam int OP_BITS = 2;

  // supported operations
  // code 3 is reserved and always yields NaR
  typedef enum logic [OP_BITS-1:0] {
    ADD      = 2'd0,
    SUB      = 2'd1,
    MUL      = 2'd2,
    RESERVED = 2'd3
  } operation_e;

endpackage : ppu_ops_pkg

`default_nettype wire

/* design/posit_fmt_pkg.sv */
// #########################################################################
// widths and types of the unpacked posit format used inside the unit
// decoder, core and encoder all exchange values in these types
// #########################################################################

`default_nettype none

package posit_fmt_pkg;

  // widest posit the internal types are sized for
  localparam int MAX_N = 16;

  // signed power-of-two scale
  // covers regime * 2^ES + exponent for ES <= 2, doubled for products
  localparam int SCALE_BITS = 8;

  typedef logic signed [SCALE_BITS-1:0] scale_t;

  // hidden one at the top bit, fraction left aligned below it
  typedef logic [MAX_N-1:0] sig_t;

  // computed significand, leading one on top
  // low bits keep the sticky information for rounding
  typedef logic [2*MAX_N-1:0] wide_sig_t;

endpackage : posit_fmt_pkg

`default_nettype wire

/* design/pipeline.sv */
// #########################################################################
// generic register delay line, depth zero degenerates to a wire
// #########################################################################

`default_nettype none

module pipeline #(
  parameter int PIPE_DEPTH = 1,
  parameter int DATA_WIDTH = 8
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic [DATA_WIDTH-1:0] data_i,
  output logic [DATA_WIDTH-1:0] data_o
);

  generate
    if (PIPE_DEPTH == 0) begin : g_wire
      // no registers at all
      assign data_o = data_i;
    end else begin : g_regs
      logic [DATA_WIDTH-1:0] stage_q [PIPE_DEPTH];

      always_ff @(posedge clk_i) begin
        if (reset_i) begin
          for (int i = 0; i < PIPE_DEPTH; i++) begin
            stage_q[i] <= '0;
          end
        end else begin
          stage_q[0] <= data_i;
          // shift toward the output end
          for (int i = 1; i < PIPE_DEPTH; i++) begin
            stage_q[i] <= stage_q[i-1];
          end
        end
      end

      assign data_o = stage_q[PIPE_DEPTH-1];
    end
  endgenerate

endmodule : pipeline

`default_nettype wire

/* design/posit_decode.sv */
// #########################################################################
// unpacks an N-bit posit into sign, scale and significand
// purely combinational, one instance per operand in the core
// #########################################################################

`default_nettype none

module posit_decode
  import posit_fmt_pkg::*;
#(
  parameter int N  = 16,
  parameter int ES = 1
) (
  input  logic [N-1:0] posit_i,
  output logic         sign_o,
  output scale_t       scale_o,
  output sig_t         sig_o,
  output logic         is_zero_o,
  output logic         is_nar_o
);

  localparam int RUN_W = $clog2(N) + 1;

  logic [N-1:0]     mag;
  logic [N-2:0]     body;
  logic [N-2:0]     rem;
  logic [N-2:0]     exp_field;
  logic [N-2:0]     frac_bits;
  logic             r0;
  logic             run_done;
  logic [RUN_W-1:0] run;
  logic [1:0]       exp_val;
  scale_t           k;

  // special patterns
  assign is_zero_o = (posit_i == '0);
  assign is_nar_o  = (posit_i == {1'b1, {(N-1){1'b0}}});
  assign sign_o    = posit_i[N-1];

  always_comb begin
    // negative posits are decoded from their two's complement
    mag  = posit_i[N-1] ? -posit_i : posit_i;
    body = mag[N-2:0];
    r0   = body[N-2];

    // regime run length, bits equal to the first one
    run      = '0;
    run_done = 1'b0;
    for (int i = N - 2; i >= 0; i--) begin
      if (!run_done && (body[i] == r0)) begin
        run = run + 1'b1;
      end else begin
        run_done = 1'b1;
      end
    end

    // run of ones gives k = run-1, run of zeros gives k = -run
    k = r0 ? (scale_t'(run) - scale_t'(1)) : -scale_t'(run);

    // drop regime and its terminating bit
    rem = body << (run + 1'b1);

    // exponent sits in the top ES bits, zero when cut off
    exp_field = rem >> (N - 1 - ES);
    exp_val   = exp_field[1:0];
    frac_bits = rem << ES;

    scale_o = (k <<< ES) + scale_t'(exp_val);

    // hidden one on top, fraction left aligned under it
    sig_o                   = '0;
    sig_o[MAX_N-1]          = 1'b1;
    sig_o[MAX_N-2 -: N - 1] = frac_bits;
  end

endmodule : posit_decode

`default_nettype wire

/* design/posit_encode.sv */
// #########################################################################
// packs sign, scale and a wide significand into an N-bit posit
// rounds once to nearest even and saturates at minpos and maxpos
// #########################################################################

`default_nettype none

module posit_encode
  import posit_fmt_pkg::*;
#(
  parameter int N  = 16,
  parameter int ES = 1
) (
  input  logic         sign_i,
  input  scale_t       scale_i,
  input  wide_sig_t    sig_i,
  input  logic         is_zero_i,
  input  logic         is_nar_i,
  output logic [N-1:0] posit_o
);

  // terminator, two exponent slots, fraction below the leading one
  localparam int TAIL_W = 2 * MAX_N + 2;
  // room to slide the tail right by the longest regime run
  localparam int STR_W  = TAIL_W + N;

  scale_t             k;
  scale_t             run;
  logic               fill;
  logic [1:0]         exp_bits;
  logic [2*MAX_N:0]   exp_frac;
  logic [TAIL_W-1:0]  tail;
  logic [STR_W-1:0]   str_base;
  logic [STR_W-1:0]   str;
  logic [N-2:0]       body;
  logic [N-2:0]       body_rnd;
  logic               guard;
  logic               sticky;
  logic               round_up;
  logic [N-1:0]       mag;

  always_comb begin
    // regime value is the floor of scale / 2^ES
    k    = scale_i >>> ES;
    fill = ~k[SCALE_BITS-1];
    // run of k+1 ones for k >= 0, -k zeros otherwise
    run  = fill ? (k + scale_t'(1)) : -k;

    // low ES bits of the scale form the exponent
    exp_bits = scale_i[1:0] & 2'((1 << ES) - 1);
    // shift out the unused exponent slots
    exp_frac = {exp_bits, sig_i[2*MAX_N-2:0]} << (2 - ES);

    // terminator is the opposite of the run bit
    tail     = {~fill, exp_frac};
    str_base = {tail, {N{1'b0}}};

    // slide right by the run, filling with the run bit
    if (fill) begin
      str = ~((~str_base) >> run);
    end else begin
      str = str_base >> run;
    end

    // posit body, then guard and sticky below it
    body   = str[STR_W-1 -: N - 1];
    guard  = str[STR_W-N];
    sticky = |str[STR_W-N-1:0];

    // ties go to the even pattern
    round_up = guard & (sticky | body[0]);
    body_rnd = body + {{(N-2){1'b0}}, round_up};

    // out of range regimes clamp, nonzero never rounds to 0 or NaR
    if (k >= scale_t'(N - 2)) begin
      mag = {1'b0, {(N-1){1'b1}}};
    end else if (k < -scale_t'(N - 2)) begin
      mag = {{(N-1){1'b0}}, 1'b1};
    end else begin
      mag = {1'b0, body_rnd};
    end

    // specials override everything
    if (is_nar_i) begin
      posit_o = {1'b1, {(N-1){1'b0}}};
    end else if (is_zero_i) begin
      posit_o = '0;
    end else if (sign_i) begin
      posit_o = -mag;
    end else begin
      posit_o = mag;
    end
  end

endmodule : posit_encode

`default_nettype wire

/* design/ppu.sv */
// #########################################################################
// posit arithmetic core for ADD, SUB and MUL
// stage 1 holds the unrounded result, stage 2 the encoded posit
// accepts one operation per cycle, result two cycles later
// #########################################################################

`default_nettype none

module ppu
  import ppu_ops_pkg::*;
  import posit_fmt_pkg::*;
#(
  parameter int N  = 16,
  parameter int ES = 1
) (
  input  logic         clk_i,
  input  logic         reset_i,
  input  logic         in_valid_i,
  input  logic [N-1:0] operand1_i,
  input  logic [N-1:0] operand2_i,
  input  operation_e   op_i,
  output logic [N-1:0] result_o,
  output logic         out_valid_o
);

  localparam int LZ_W = $clog2(2 * MAX_N) + 1;

  // decoded operands
  logic   sign_a, zero_a, nar_a;
  logic   sign_b, zero_b, nar_b;
  scale_t scale_a, scale_b;
  sig_t   sig_a, sig_b;

  // add path, x is the larger magnitude
  logic                  sign_b_eff;
  logic                  a_big;
  logic                  sign_x, sign_y;
  scale_t                scale_x, scale_y;
  logic [SCALE_BITS-1:0] diff;
  wide_sig_t             wx, wy, wy_sh, lost_mask, sum;
  logic                  sticky;
  logic [LZ_W-1:0]       lz;
  logic                  lz_found;
  wide_sig_t             add_sig;
  scale_t                add_scale;

  // mul path
  wide_sig_t prod;
  wide_sig_t mul_sig;
  scale_t    mul_scale;

  // selected unrounded result
  logic      res_sign, res_zero, res_nar;
  scale_t    res_scale;
  wide_sig_t res_sig;

  // stage 1
  logic      s1_valid, s1_sign, s1_zero, s1_nar;
  scale_t    s1_scale;
  wide_sig_t s1_sig;

  logic [N-1:0] enc_posit;

  posit_decode #(.N(N), .ES(ES)) dec_a (
    .posit_i   (operand1_i),
    .sign_o    (sign_a),
    .scale_o   (scale_a),
    .sig_o     (sig_a),
    .is_zero_o (zero_a),
    .is_nar_o  (nar_a)
  );

  posit_decode #(.N(N), .ES(ES)) dec_b (
    .posit_i   (operand2_i),
    .sign_o    (sign_b),
    .scale_o   (scale_b),
    .sig_o     (sig_b),
    .is_zero_o (zero_b),
    .is_nar_o  (nar_b)
  );

  always_comb begin
    // SUB is ADD with the second operand negated
    sign_b_eff = sign_b ^ (op_i == SUB);
    a_big      = (scale_a > scale_b) || ((scale_a == scale_b) && (sig_a >= sig_b));
    sign_x     = a_big ? sign_a : sign_b_eff;
    sign_y     = a_big ? sign_b_eff : sign_a;
    scale_x    = a_big ? scale_a : scale_b;
    scale_y    = a_big ? scale_b : scale_a;

    // one carry slot above the hidden bit
    wx = {1'b0, (a_big ? sig_a : sig_b), {(MAX_N-1){1'b0}}};
    wy = {1'b0, (a_big ? sig_b : sig_a), {(MAX_N-1){1'b0}}};

    // align y, bits shifted out collapse into a sticky lsb
    diff      = scale_x - scale_y;
    wy_sh     = wy >> diff;
    lost_mask = ~({(2*MAX_N){1'b1}} << diff);
    sticky    = |(wy & lost_mask);

    if (sign_x == sign_y) begin
      sum = wx + (wy_sh | sticky);
    end else begin
      sum = wx - (wy_sh | sticky);
    end

    // leading zero count for normalization
    lz       = '0;
    lz_found = 1'b0;
    for (int i = 2 * MAX_N - 1; i >= 0; i--) begin
      if (!lz_found) begin
        if (sum[i]) begin
          lz_found = 1'b1;
        end else begin
          lz = lz + 1'b1;
        end
      end
    end
    add_sig   = sum << lz;
    add_scale = scale_x + scale_t'(1) - scale_t'(lz);
  end

  always_comb begin
    // product of two [1,2) values lies in [1,4)
    prod = wide_sig_t'(sig_a) * wide_sig_t'(sig_b);
    if (prod[2*MAX_N-1]) begin
      mul_sig   = prod;
      mul_scale = scale_a + scale_b + scale_t'(1);
    end else begin
      mul_sig   = prod << 1;
      mul_scale = scale_a + scale_b;
    end
  end

  always_comb begin
    res_nar   = nar_a | nar_b | (op_i == RESERVED);
    res_zero  = 1'b0;
    res_sign  = sign_x;
    res_scale = add_scale;
    res_sig   = add_sig;
    case (op_i)
      MUL: begin
        res_zero  = zero_a | zero_b;
        res_sign  = sign_a ^ sign_b;
        res_scale = mul_scale;
        res_sig   = mul_sig;
      end
      default: begin
        // a zero operand passes the other one through exactly
        if (zero_a && zero_b) begin
          res_zero = 1'b1;
        end else if (zero_a) begin
          res_sign  = sign_b_eff;
          res_scale = scale_b;
          res_sig   = {sig_b, {MAX_N{1'b0}}};
        end else if (zero_b) begin
          res_sign  = sign_a;
          res_scale = scale_a;
          res_sig   = {sig_a, {MAX_N{1'b0}}};
        end else begin
          // exact cancellation, x - x
          res_zero = ~lz_found;
        end
      end
    endcase
  end

  // stage 1, unrounded result
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i) begin
      s1_sign  <= res_sign;
      s1_scale <= res_scale;
      s1_sig   <= res_sig;
      s1_zero  <= res_zero;
      s1_nar   <= res_nar;
    end
  end

  posit_encode #(.N(N), .ES(ES)) enc (
    .sign_i    (s1_sign),
    .scale_i   (s1_scale),
    .sig_i     (s1_sig),
    .is_zero_i (s1_zero),
    .is_nar_i  (s1_nar),
    .posit_o   (enc_posit)
  );

  // stage 2, result only moves with a valid
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_valid_o <= 1'b0;
      result_o    <= '0;
    end else begin
      out_valid_o <= s1_valid;
      if (s1_valid) begin
        result_o <= enc_posit;
      end
    end
  end

endmodule : ppu

`default_nettype wire

/* design/ppu_top.sv */
// #########################################################################
// top level of the posit unit, core wrapped in register stages
// one register in front when PIPE_DEPTH >= 1, the rest behind the core
// latency from in_valid_i to out_valid_o is PIPE_DEPTH + 2 cycles
// #########################################################################

`default_nettype none

module ppu_top
  import ppu_ops_pkg::*;
#(
  parameter int N          = 16,
  parameter int ES         = 1,
  parameter int PIPE_DEPTH = 2
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               in_valid_i,
  input  logic [N-1:0]       operand1_i,
  input  logic [N-1:0]       operand2_i,
  input  logic [OP_BITS-1:0] op_i,
  output logic [N-1:0]       result_o,
  output logic               out_valid_o
);

  // split of the extra registers around the core
  localparam int PIPE_DEPTH_FRONT = (PIPE_DEPTH >= 1) ? 1 : 0;
  localparam int PIPE_DEPTH_BACK  = PIPE_DEPTH - PIPE_DEPTH_FRONT;

  localparam int IN_W  = 1 + OP_BITS + 2 * N;
  localparam int OUT_W = N + 1;

  // core side of the front stage
  logic               in_valid_st0;
  logic [OP_BITS-1:0] op_st0;
  logic [N-1:0]       operand1_st0;
  logic [N-1:0]       operand2_st0;

  // core outputs before the back stages
  logic [N-1:0] result_st0;
  logic         out_valid_st0;

  pipeline #(
    .PIPE_DEPTH (PIPE_DEPTH_FRONT),
    .DATA_WIDTH (IN_W)
  ) pipeline_in (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  ({in_valid_i, op_i, operand1_i, operand2_i}),
    .data_o  ({in_valid_st0, op_st0, operand1_st0, operand2_st0})
  );

  ppu #(
    .N  (N),
    .ES (ES)
  ) ppu_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_valid_i  (in_valid_st0),
    .operand1_i  (operand1_st0),
    .operand2_i  (operand2_st0),
    .op_i        (operation_e'(op_st0)),
    .result_o    (result_st0),
    .out_valid_o (out_valid_st0)
  );

  pipeline #(
    .PIPE_DEPTH (PIPE_DEPTH_BACK),
    .DATA_WIDTH (OUT_W)
  ) pipeline_out (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  ({result_st0, out_valid_st0}),
    .data_o  ({result_o, out_valid_o})
  );

endmodule : ppu_top

`default_nettype wire

/* test/ppu_top_sva.sv */
// ##########################################################################
// concurrent checks on the ppu_top ports
// bound into every ppu_top instance
// ##########################################################################

`default_nettype none

module ppu_top_sva #(
  parameter int N          = 16,
  parameter int PIPE_DEPTH = 2
) (
  input logic         clk_i,
  input logic         reset_i,
  input logic         in_valid_i,
  input logic [N-1:0] result_o,
  input logic         out_valid_o
);

  // core adds two stages to the wrapper registers
  localparam int LATENCY = PIPE_DEPTH + 2;

  // every valid register clears in the reset cycle
  a_idle_after_reset: assert property (@(posedge clk_i) reset_i |=> !out_valid_o)
    else $error("out_valid_o high right after reset");

  // each strobe comes out a fixed number of cycles later
  a_strobe_to_valid: assert property (
    @(posedge clk_i) disable iff (reset_i) in_valid_i |-> ##LATENCY out_valid_o)
    else $error("no out_valid_o %0d cycles after in_valid_i", LATENCY);

  // and no valid appears without a strobe
  a_valid_from_strobe: assert property (
    @(posedge clk_i) disable iff (reset_i) out_valid_o |-> $past(in_valid_i, LATENCY))
    else $error("out_valid_o without a matching in_valid_i");

  a_result_known: assert property (
    @(posedge clk_i) disable iff (reset_i) out_valid_o |-> !$isunknown(result_o))
    else $error("result_o unknown while out_valid_o is high");

endmodule : ppu_top_sva

bind ppu_top ppu_top_sva #(
  .N          (N),
  .PIPE_DEPTH (PIPE_DEPTH)
) ppu_top_sva_inst (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .in_valid_i  (in_valid_i),
  .result_o    (result_o),
  .out_valid_o (out_valid_o)
);

`default_nettype wire

/* test/tb_ppu_top.sv */
// ##########################################################################
// random ADD, SUB and MUL on ppu_top checked bit for bit
// against an exact integer model with posit bit string rounding
// ##########################################################################

`default_nettype none

module tb_ppu_top
  import ppu_ops_pkg::*;
();

  localparam int N          = 16;
  localparam int ES         = 1;
  localparam int PIPE_DEPTH = 2;
  localparam int LATENCY    = PIPE_DEPTH + 2;
  localparam int NUM_OPS    = 10000;
  // one idle cycle in sixteen on average plus reset and drain
  localparam int MAX_CYCLES = NUM_OPS + NUM_OPS / 5;

  localparam logic [N-1:0] NAR    = {1'b1, {(N-1){1'b0}}};
  localparam logic [N-1:0] MAXPOS = {1'b0, {(N-1){1'b1}}};
  localparam logic [N-1:0] MINPOS = {{(N-1){1'b0}}, 1'b1};

  logic               clk;
  logic               reset;
  logic               in_valid;
  logic [OP_BITS-1:0] op;
  logic [N-1:0]       operand1;
  logic [N-1:0]       operand2;
  logic [N-1:0]       result;
  logic               out_valid;

  int          cycle;
  int          issued;
  logic [31:0] rng;

  // scoreboard of expected posits and the cycle each is due
  logic [N-1:0] exp_q [$];
  int           due_q [$];
  string        desc_q [$];

  ppu_top #(
    .N          (N),
    .ES         (ES),
    .PIPE_DEPTH (PIPE_DEPTH)
  ) i_dut (
    .clk_i       (clk),
    .reset_i     (reset),
    .in_valid_i  (in_valid),
    .operand1_i  (operand1),
    .operand2_i  (operand2),
    .op_i        (op),
    .result_o    (result),
    .out_valid_o (out_valid)
  );

  always #2 clk = ~clk;

  // cycle count that also guards against a hung run
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Result: FAILED");
      $fatal(1, "simulation stopped by timeout");
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] s;
    s = state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic expect_equal(input logic [N-1:0] actual, input logic [N-1:0] expected,
                              input string what);
    if (actual !== expected) begin
      $display("mismatch at time %0t: %s, expected %h, got %h", $time, what, expected, actual);
      $display("Result: FAILED");
      $fatal(1, "output check failed");
    end
  endtask

  // exact value as (-1)^sgn * sig * 2^expo
  // zero gives sig = 0
  function automatic void decode_exact(input logic [N-1:0] p, output logic sgn,
                                       output logic [127:0] sig, output int expo);
    logic [N-1:0] mag;
    logic         r0;
    int           i;
    int           run;
    int           k;
    int           e;
    int           nf;
    sgn  = p[N-1];
    mag  = sgn ? -p : p;
    sig  = '0;
    expo = 0;
    if (p == '0) begin
      return;
    end
    // regime read from the top
    r0  = mag[N-2];
    i   = N - 2;
    run = 0;
    while (i >= 0 && mag[i] == r0) begin
      run++;
      i--;
    end
    k = r0 ? run - 1 : -run;
    // skip the terminating bit
    i--;
    // exponent bits past the end read as zero
    e = 0;
    for (int j = 0; j < ES; j++) begin
      e = 2 * e + ((i >= 0) ? int'(mag[i]) : 0);
      i--;
    end
    nf = (i >= 0) ? i + 1 : 0;
    sig[nf] = 1'b1;
    for (int j = 0; j < nf; j++) begin
      sig[j] = mag[j];
    end
    expo = k * (1 << ES) + e - nf;
  endfunction

  // builds the full regime, exponent and fraction stream bit by bit
  // and rounds the first N-1 bits to nearest even
  function automatic logic [N-1:0] encode_exact(input logic sgn, input logic [127:0] m,
                                                input int base);
    int           p;
    int           scale;
    int           k;
    int           e;
    int           run;
    int           len;
    logic         b;
    logic [N-2:0] body;
    logic         guard;
    logic         sticky;
    logic [N-1:0] mag;
    if (m == '0) begin
      return '0;
    end
    p = 0;
    for (int j = 0; j < 128; j++) begin
      if (m[j]) begin
        p = j;
      end
    end
    scale = p + base;
    // floor division that also holds for negative scales
    if (scale >= 0) begin
      k = scale / (1 << ES);
    end else begin
      k = -((-scale + (1 << ES) - 1) / (1 << ES));
    end
    e      = scale - k * (1 << ES);
    run    = (k >= 0) ? k + 1 : -k;
    len    = run + 1 + ES + p;
    body   = '0;
    guard  = 1'b0;
    sticky = 1'b0;
    for (int idx = 0; idx < len; idx++) begin
      if (idx < run) begin
        b = (k >= 0);
      end else if (idx == run) begin
        b = (k < 0);
      end else if (idx < run + 1 + ES) begin
        b = e[ES - 1 - (idx - run - 1)];
      end else begin
        b = m[p - 1 - (idx - run - 1 - ES)];
      end
      if (idx < N - 1) begin
        body[N - 2 - idx] = b;
      end else if (idx == N - 1) begin
        guard = b;
      end else begin
        sticky = sticky | b;
      end
    end
    mag = {1'b0, body} + N'(guard & (sticky | body[0]));
    // nonzero values saturate instead of reaching NaR or zero
    if (mag[N-1]) begin
      mag = MAXPOS;
    end else if (mag == '0) begin
      mag = MINPOS;
    end
    return sgn ? -mag : mag;
  endfunction

  function automatic logic [N-1:0] model_result(input logic [OP_BITS-1:0] code,
                                                input logic [N-1:0] a, input logic [N-1:0] b);
    logic                sa;
    logic                sb;
    logic [127:0]        ma;
    logic [127:0]        mb;
    int                  ea;
    int                  eb;
    int                  e0;
    logic signed [129:0] va;
    logic signed [129:0] vb;
    logic signed [129:0] sum;
    if (code == RESERVED || a == NAR || b == NAR) begin
      return NAR;
    end
    decode_exact(a, sa, ma, ea);
    decode_exact(b, sb, mb, eb);
    if (code == MUL) begin
      return encode_exact(sa ^ sb, ma * mb, ea + eb);
    end
    if (code == SUB) begin
      sb = ~sb;
    end
    // exact sum on a common binary point
    e0  = (ea < eb) ? ea : eb;
    va  = $signed({2'b00, ma << (ea - e0)});
    vb  = $signed({2'b00, mb << (eb - e0)});
    va  = sa ? -va : va;
    vb  = sb ? -vb : vb;
    sum = va + vb;
    if (sum < 0) begin
      return encode_exact(1'b1, 128'(-sum), e0);
    end
    return encode_exact(1'b0, 128'(sum), e0);
  endfunction

  function automatic logic [N-1:0] pick_operand(input logic [31:0] r);
    logic [N-1:0] v;
    case (r[3:0])
      4'd0: v = '0;
      4'd1: v = NAR;
      // long run of ones so products overflow to maxpos
      4'd2: v = {2'b01, {(N-6){1'b1}}, r[7:4]};
      // long run of zeros so products underflow to minpos
      4'd3: v = {{(N-4){1'b0}}, r[7:4]};
      default: v = r[16 +: N];
    endcase
    if (r[8] && (r[3:1] == 3'b001)) begin
      v = -v;
    end
    return v;
  endfunction

  task automatic check_outputs();
    logic expect_valid;
    expect_valid = (due_q.size() > 0) && (due_q[0] == cycle);
    expect_equal(N'(out_valid), N'(expect_valid), "out_valid_o");
    if (expect_valid) begin
      expect_equal(result, exp_q[0], desc_q[0]);
      void'(exp_q.pop_front());
      void'(due_q.pop_front());
      void'(desc_q.pop_front());
    end
  endtask

  task automatic drive_random();
    logic [31:0]        r_ctl;
    logic [31:0]        r_a;
    logic [31:0]        r_b;
    logic [OP_BITS-1:0] code;
    logic [N-1:0]       a;
    logic [N-1:0]       b;
    rng   = xorshift32(rng);
    r_ctl = rng;
    rng   = xorshift32(rng);
    r_a   = rng;
    rng   = xorshift32(rng);
    r_b   = rng;
    code  = r_ctl[1:0];
    // reserved opcode only now and then
    if (code == RESERVED && r_ctl[6:4] != 3'd0) begin
      code = r_ctl[7] ? SUB : MUL;
    end
    a = pick_operand(r_a);
    // x - x and near cancellation
    case (r_b[11:9])
      3'd0: b = a;
      3'd1: b = a ^ N'(r_b[15:12]);
      default: b = pick_operand(r_b);
    endcase
    in_valid = (r_ctl[31:28] != 4'd0);
    op       = code;
    operand1 = a;
    operand2 = b;
    if (in_valid) begin
      exp_q.push_back(model_result(code, a, b));
      due_q.push_back(cycle + LATENCY);
      desc_q.push_back($sformatf("result_o for op %0d on %h and %h", code, a, b));
      issued++;
    end
  endtask

  initial begin
    clk      = 1'b0;
    reset    = 1'b1;
    in_valid = 1'b0;
    op       = '0;
    operand1 = '0;
    operand2 = '0;
    cycle    = 0;
    issued   = 0;
    rng      = 32'hdde0_5bce;

    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // nothing may come out before the first strobe
    repeat (6) begin
      @(negedge clk);
      check_outputs();
    end

    while (issued < NUM_OPS) begin
      @(negedge clk);
      check_outputs();
      drive_random();
    end

    // drain and then idle long enough to catch a stray valid
    while (exp_q.size() > 0) begin
      @(negedge clk);
      check_outputs();
      in_valid = 1'b0;
    end
    repeat (2 * LATENCY) begin
      @(negedge clk);
      check_outputs();
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule : tb_ppu_top

`default_nettype wire

/* sim.f */
design/ppu_ops_pkg.sv
design/posit_fmt_pkg.sv
design/pipeline.sv
design/posit_decode.sv
design/posit_encode.sv
design/ppu.sv
design/ppu_top.sv
test/ppu_top_sva.sv
test/tb_ppu_top.sv

/* Makefile */
# Verilator flow for the posit unit testbench
# override any variable on the command line, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_ppu_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS  ?=

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulation is the pass or fail result
run: compile
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
